//--- include/txController_defines.svh
`ifndef TXCONTROLLER_DEFINES_SVH
`define TXCONTROLLER_DEFINES_SVH

// transducer channels and their timing widths
`define CHANNELS 8
`define PHASE_W 16
`define CHARGE_W 9

// control word fields
`define MODE_LSB 0
`define MODE_W 2
`define CMD_LSB 2
`define CMD_W 9
`define TRIG_LSB 11
`define TRIG_W 8
`define LED_LSB 19
`define LED_W 7
`define ATTEN_BIT 26
`define CHARGE_SEL_LSB 27
`define CHARGE_SEL_W 2
`define ASYNC_BIT 29

// bit index inside the command field, one hot per command
`define CMD_FIRE 1
`define CMD_SET_PHASE 2
`define CMD_SET_TRIG_LEDS 3
`define CMD_ISSUE_RCV_TRIG 4
`define CMD_ASYNC_RCV_TRIG 5
`define CMD_SET_VAR_ATTEN 6
`define CMD_RESET_INTERRUPT 8

// interrupt word bits
`define IRQ_CMD 0
`define IRQ_RCV_DONE 3
`define IRQ_EMERGENCY 31

`endif

//--- hw/txControllerPkg.sv
package txControllerPkg;

	// control mode, bits 1:0 of the control word
	// both RAM modes are not implemented and act like idle
	typedef enum logic [1:0]
	{
		modeIdle       = 2'b00,
		modePio        = 2'b01,
		modeRam        = 2'b10,
		modeRamSubcall = 2'b11
	} txMode;

endpackage

//--- hw/pioCommandDecoder.sv
`include "txController_defines.svh"

module pioCommandDecoder
	import txControllerPkg::*;
(
	input  logic                      txCLK,
	input  logic                      reset,
	input  logic [31:0]               controlComms,
	output txMode                     mode,
	output logic                      cmdValid,
	output logic [`CMD_W-1:0]         cmd,
	output logic [`TRIG_W-1:0]        trigBits,
	output logic [`LED_W-1:0]         ledBits,
	output logic                      attenBit,
	output logic [`CHARGE_SEL_W-1:0]  chargeSel,
	output logic                      asyncRcv
);

	logic [`ASYNC_BIT:0] wordReg;   // bits above the async flag are unused
	logic [`CMD_W-1:0]   prevCmd;
	txMode               wordMode;
	logic [`CMD_W-1:0]   wordCmd;

	assign wordMode = txMode'(wordReg[`MODE_LSB +: `MODE_W]);
	assign wordCmd  = wordReg[`CMD_LSB +: `CMD_W];

	// first stage, sample the PIO register
	always_ff @(posedge txCLK)
	begin
		if (reset)
			wordReg <= '0;
		else
			wordReg <= controlComms[`ASYNC_BIT:0];
	end

	// a command acts only when its field changes
	always_ff @(posedge txCLK)
	begin
		if (reset)
		begin
			mode     <= modeIdle;
			cmdValid <= 1'b0;
			prevCmd  <= '0;
		end
		else
		begin
			mode <= wordMode;
			case (wordMode)
				modePio:
				begin
					prevCmd  <= wordCmd;
					cmdValid <= (wordCmd != '0) && (wordCmd != prevCmd);
				end
				default:
				begin
					prevCmd  <= '0;   // forget, so a later PIO session repeats it
					cmdValid <= 1'b0;
				end
			endcase
		end
	end

	// fields travel alongside the strobe
	always_ff @(posedge txCLK)
	begin
		cmd       <= wordCmd;
		trigBits  <= wordReg[`TRIG_LSB +: `TRIG_W];
		ledBits   <= wordReg[`LED_LSB +: `LED_W];
		attenBit  <= wordReg[`ATTEN_BIT];
		chargeSel <= wordReg[`CHARGE_SEL_LSB +: `CHARGE_SEL_W];
		asyncRcv  <= wordReg[`ASYNC_BIT];
	end

endmodule

//--- hw/pioSequencer.sv
`include "txController_defines.svh"

module pioSequencer
	import txControllerPkg::*;
(
	input  logic                                  txCLK,
	input  logic                                  reset,
	input  txMode                                 mode,
	input  logic                                  cmdValid,
	input  logic [`CMD_W-1:0]                     cmd,
	input  logic [`TRIG_W-1:0]                    trigBits,
	input  logic [`LED_W-1:0]                     ledBits,
	input  logic                                  attenBit,
	input  logic [`CHARGE_SEL_W-1:0]              chargeSel,
	input  logic                                  asyncRcv,
	input  logic [31:0]                           chargeTimeReg,
	input  logic [31:0]                           phaseDelay01,
	input  logic [31:0]                           phaseDelay23,
	input  logic [31:0]                           phaseDelay45,
	input  logic [31:0]                           phaseDelay67,
	input  logic [`TRIG_W-1:0]                    triggerRestLevels,
	input  logic [`LED_W-1:0]                     ledRestLevels,
	input  logic [`CHANNELS-1:0]                  transducerMask,
	input  logic                                  adcTriggerAck,
	input  logic [`CHANNELS-1:0]                  fireDone,
	output logic                                  fireStart,
	output logic [`CHARGE_W-1:0]                  chargeTime,
	output logic [`CHANNELS-1:0][`PHASE_W-1:0]    phaseDelays,
	output logic [`CHANNELS-1:0]                  channelMask,
	output logic [`TRIG_W-1:0]                    triggerOutputs,
	output logic [`LED_W-1:0]                     ledOutputs,
	output logic                                  varRxAtten,
	output logic                                  adcTriggerLine,
	output logic [31:0]                           interrupt,
	output logic                                  emergency
);

	logic       busy;        // a fire is running on some channel
	logic       rcvSync;     // pending ADC trigger was a synchronous one
	logic [7:0] chargeByte;
	logic       issueRcv;
	logic       asyncIssue;

	assign chargeByte = chargeTimeReg[{chargeSel, 3'b000} +: 8];

	// the async command bit implies an issue, the async field only changes its kind
	assign issueRcv   = cmd[`CMD_ISSUE_RCV_TRIG] | cmd[`CMD_ASYNC_RCV_TRIG];
	assign asyncIssue = cmd[`CMD_ASYNC_RCV_TRIG] | asyncRcv;

	always_ff @(posedge txCLK)
	begin
		if (reset)
		begin
			fireStart      <= 1'b0;
			busy           <= 1'b0;
			channelMask    <= '0;
			chargeTime     <= '0;
			phaseDelays    <= '0;
			triggerOutputs <= triggerRestLevels;
			ledOutputs     <= ledRestLevels;
			varRxAtten     <= 1'b0;
			adcTriggerLine <= 1'b0;
			rcvSync        <= 1'b0;
			interrupt      <= '0;
			emergency      <= 1'b0;
		end
		else
		begin
			fireStart <= 1'b0;

			// channels still report done on the edge that sees fireStart
			if (busy && !fireStart && (&fireDone))
				busy <= 1'b0;

			if (adcTriggerLine && adcTriggerAck)
			begin
				adcTriggerLine <= 1'b0;
				if (rcvSync)
					interrupt[`IRQ_RCV_DONE] <= 1'b1;
			end

			case (mode)
				modePio:
				begin
					if (cmdValid)
					begin
						if (cmd[`CMD_RESET_INTERRUPT])
							interrupt <= '0;
						else
							interrupt[`IRQ_CMD] <= 1'b1;

						// delays and charge time stay put while a fire runs
						if (cmd[`CMD_SET_PHASE] && !busy)
						begin
							chargeTime  <= {chargeByte, 1'b1};
							phaseDelays <= {phaseDelay67, phaseDelay45,
								phaseDelay23, phaseDelay01};
						end

						if (cmd[`CMD_FIRE])
						begin
							if (busy)
							begin
								emergency                  <= 1'b1;   // sticky
								interrupt[`IRQ_EMERGENCY]  <= 1'b1;
							end
							else
							begin
								fireStart   <= 1'b1;
								busy        <= 1'b1;
								channelMask <= transducerMask;
							end
						end

						if (cmd[`CMD_SET_TRIG_LEDS])
						begin
							triggerOutputs <= trigBits ^ triggerRestLevels;
							ledOutputs     <= ledBits ^ ledRestLevels;
						end

						if (cmd[`CMD_SET_VAR_ATTEN])
							varRxAtten <= attenBit;

						if (issueRcv && !adcTriggerLine)
						begin
							adcTriggerLine <= 1'b1;
							rcvSync        <= !asyncIssue;
						end
					end
				end
				default:
				begin
					// idle and the RAM modes rest all outputs
					triggerOutputs <= triggerRestLevels;
					ledOutputs     <= ledRestLevels;
					varRxAtten     <= 1'b0;
					adcTriggerLine <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- hw/pulseChannel.sv
`include "txController_defines.svh"

module pulseChannel
(
	input  logic                  txCLK,
	input  logic                  reset,
	input  logic                  fireStart,
	input  logic                  mask,
	input  logic [`CHARGE_W-1:0]  chargeTime,
	input  logic [`PHASE_W-1:0]   phaseDelay,
	output logic                  transducerOutput,
	output logic                  fireDone
);

	localparam logic [1:0] stDelay = 2'd0;
	localparam logic [1:0] stPulse = 2'd1;
	localparam logic [1:0] stDone  = 2'd2;

	logic [1:0]          state;
	logic [`PHASE_W-1:0] count;    // shared by delay and pulse
	logic [`PHASE_W-1:0] pulseLoad;

	// charge time minus one, widened to the counter
	assign pulseLoad = {{(`PHASE_W-`CHARGE_W){1'b0}}, chargeTime - 1'b1};

	always_ff @(posedge txCLK)
	begin
		if (reset)
		begin
			state <= stDone;
			count <= '0;
		end
		else if (fireStart)
		begin
			if (!mask)
				state <= stDone;   // masked channel never pulses
			else if (phaseDelay == '0)
			begin
				state <= stPulse;
				count <= pulseLoad;
			end
			else
			begin
				state <= stDelay;
				count <= phaseDelay - 1'b1;
			end
		end
		else
		begin
			case (state)
				stDelay:
				begin
					if (count == '0)
					begin
						state <= stPulse;
						count <= pulseLoad;
					end
					else
						count <= count - 1'b1;
				end
				stPulse:
				begin
					if (count == '0)
						state <= stDone;
					else
						count <= count - 1'b1;
				end
				default:
					state <= stDone;
			endcase
		end
	end

	assign transducerOutput = (state == stPulse);
	assign fireDone         = (state == stDone);

endmodule

//--- hw/txController.sv
`include "txController_defines.svh"

module txController
	import txControllerPkg::*;
(
	input  logic                  txCLK,
	input  logic                  reset,
	input  logic [31:0]           controlComms,
	input  logic [31:0]           chargeTimeReg,
	input  logic [31:0]           phaseDelay01,
	input  logic [31:0]           phaseDelay23,
	input  logic [31:0]           phaseDelay45,
	input  logic [31:0]           phaseDelay67,
	input  logic [`TRIG_W-1:0]    triggerRestLevels,
	input  logic [`LED_W-1:0]     ledRestLevels,
	input  logic [`CHANNELS-1:0]  transducerMask,
	input  logic                  adcTriggerAck,
	output logic [`CHANNELS-1:0]  transducerOutput,
	output logic [`TRIG_W-1:0]    triggerOutputs,
	output logic [`LED_W-1:0]     ledOutputs,
	output logic                  varRxAtten,
	output logic                  adcTriggerLine,
	output logic [31:0]           interrupt,
	output logic                  emergency
);

	// decoder to sequencer
	txMode                          mode;
	logic                           cmdValid;
	logic [`CMD_W-1:0]              cmd;
	logic [`TRIG_W-1:0]             trigBits;
	logic [`LED_W-1:0]              ledBits;
	logic                           attenBit;
	logic [`CHARGE_SEL_W-1:0]       chargeSel;
	logic                           asyncRcv;

	// sequencer to channels
	logic                           fireStart;
	logic [`CHARGE_W-1:0]           chargeTime;
	logic [`CHANNELS-1:0][`PHASE_W-1:0] phaseDelays;
	logic [`CHANNELS-1:0]           channelMask;
	logic [`CHANNELS-1:0]           fireDone;

	pioCommandDecoder decoder
	(
		.txCLK        (txCLK),
		.reset        (reset),
		.controlComms (controlComms),
		.mode         (mode),
		.cmdValid     (cmdValid),
		.cmd          (cmd),
		.trigBits     (trigBits),
		.ledBits      (ledBits),
		.attenBit     (attenBit),
		.chargeSel    (chargeSel),
		.asyncRcv     (asyncRcv)
	);

	pioSequencer sequencer
	(
		.txCLK             (txCLK),
		.reset             (reset),
		.mode              (mode),
		.cmdValid          (cmdValid),
		.cmd               (cmd),
		.trigBits          (trigBits),
		.ledBits           (ledBits),
		.attenBit          (attenBit),
		.chargeSel         (chargeSel),
		.asyncRcv          (asyncRcv),
		.chargeTimeReg     (chargeTimeReg),
		.phaseDelay01      (phaseDelay01),
		.phaseDelay23      (phaseDelay23),
		.phaseDelay45      (phaseDelay45),
		.phaseDelay67      (phaseDelay67),
		.triggerRestLevels (triggerRestLevels),
		.ledRestLevels     (ledRestLevels),
		.transducerMask    (transducerMask),
		.adcTriggerAck     (adcTriggerAck),
		.fireDone          (fireDone),
		.fireStart         (fireStart),
		.chargeTime        (chargeTime),
		.phaseDelays       (phaseDelays),
		.channelMask       (channelMask),
		.triggerOutputs    (triggerOutputs),
		.ledOutputs        (ledOutputs),
		.varRxAtten        (varRxAtten),
		.adcTriggerLine    (adcTriggerLine),
		.interrupt         (interrupt),
		.emergency         (emergency)
	);

	for (genvar i = 0; i < `CHANNELS; i++)
	begin : channel
		pulseChannel pulser
		(
			.txCLK            (txCLK),
			.reset            (reset),
			.fireStart        (fireStart),
			.mask             (channelMask[i]),
			.chargeTime       (chargeTime),
			.phaseDelay       (phaseDelays[i]),
			.transducerOutput (transducerOutput[i]),
			.fireDone         (fireDone[i])
		);
	end

endmodule

//--- verif/txController_properties.sv
`include "txController_defines.svh"

module txControllerProperties
(
	input logic                  txCLK,
	input logic                  reset,
	input logic                  cmdValid,
	input logic [`CHANNELS-1:0]  transducerOutput,
	input logic [`CHANNELS-1:0]  channelMask,
	input logic                  adcTriggerLine,
	input logic                  adcTriggerAck
);
	timeunit 1ns;
	timeprecision 1ns;

	int unsigned failures = 0;   // failed assertions so far

	// the decoder strobe is a single cycle
	strobeOneCycle: assert property (@(posedge txCLK) disable iff (reset)
		cmdValid |=> !cmdValid)
	else
	begin
		$error("cmdValid high for two cycles in a row");
		failures++;
	end

	maskedStaysLow: assert property (@(posedge txCLK) disable iff (reset)
		(transducerOutput & ~channelMask) == '0)
	else
	begin
		$error("transducer output high on a masked channel");
		failures++;
	end

	// acknowledge drops the ADC line on the next edge
	ackDropsLine: assert property (@(posedge txCLK) disable iff (reset)
		(adcTriggerLine && adcTriggerAck) |=> !adcTriggerLine)
	else
	begin
		$error("adcTriggerLine still high after acknowledge");
		failures++;
	end

endmodule

//--- verif/txControllerTb.sv
`include "txController_defines.svh"

module txControllerTb
	import txControllerPkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int          trigRest  = 'hA5;
	localparam int          ledRest   = 'h2C;
	localparam logic [7:0]  maskValue = 8'b1011_0111;   // channels 3 and 6 off
	localparam logic [31:0] chargeReg = 32'h0603_0204;
	localparam int          chargeSelUsed = 2;
	localparam int          pulseLen = 2 * int'(chargeReg[8*chargeSelUsed +: 8]) + 1;

	localparam logic [8:0] fireCmd  = 9'd1 << `CMD_FIRE;
	localparam logic [8:0] phaseCmd = 9'd1 << `CMD_SET_PHASE;
	localparam logic [8:0] trigCmd  = 9'd1 << `CMD_SET_TRIG_LEDS;
	localparam logic [8:0] issueCmd = 9'd1 << `CMD_ISSUE_RCV_TRIG;
	localparam logic [8:0] attenCmd = 9'd1 << `CMD_SET_VAR_ATTEN;
	localparam logic [8:0] clearCmd = 9'd1 << `CMD_RESET_INTERRUPT;

	// one table row holds a control word and the outputs expected after it
	typedef struct packed {
		logic [31:0] word;
		logic        ack;
		logic        fires;
		logic [7:0]  hold;    // extra cycles before the check
		logic [7:0]  trig;
		logic [6:0]  led;
		logic        atten;
		logic        adc;
		logic [31:0] irq;
		logic        emerg;
	} stepT;

	logic        txCLK;
	logic        reset;
	logic [31:0] controlComms;
	logic [31:0] chargeTimeReg;
	logic [31:0] phaseDelay01;
	logic [31:0] phaseDelay23;
	logic [31:0] phaseDelay45;
	logic [31:0] phaseDelay67;
	logic [7:0]  triggerRestLevels;
	logic [6:0]  ledRestLevels;
	logic [7:0]  transducerMask;
	logic        adcTriggerAck;
	logic [7:0]  transducerOutput;
	logic [7:0]  triggerOutputs;
	logic [6:0]  ledOutputs;
	logic        varRxAtten;
	logic        adcTriggerLine;
	logic [31:0] interrupt;
	logic        emergency;

	stepT        steps[$];
	logic [15:0] delays [8] = '{16'd3, 16'd0, 16'd7, 16'd1, 16'd5, 16'd2, 16'd9, 16'd4};
	int          cycles = 0;
	int          cycleLimit = 0;
	int          fireEdge = 0;     // edge N of the last accepted fire
	logic        fireArmed = 1'b0;
	logic [7:0]  fireMask = '0;

	txController DUT (.*);

	bind txController txControllerProperties props
	(
		.txCLK            (txCLK),
		.reset            (reset),
		.cmdValid         (cmdValid),
		.transducerOutput (transducerOutput),
		.channelMask      (channelMask),
		.adcTriggerLine   (adcTriggerLine),
		.adcTriggerAck    (adcTriggerAck)
	);

	initial
	begin
		txCLK = 1'b0;
		forever #50 txCLK = ~txCLK;
	end

	always @(posedge txCLK)
		cycles <= cycles + 1;

	task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
		if (got !== expected)
		begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Something failed");
			$fatal(1, "stopping at the first error");
		end
	endtask

	function automatic logic [31:0] pioWord(input logic [8:0] c, input int trig, input int led,
		input int atten, input int sel, input int async);
		logic [31:0] w;
		w = '0;
		w[`MODE_LSB +: `MODE_W]             = modePio;
		w[`CMD_LSB +: `CMD_W]               = c;
		w[`TRIG_LSB +: `TRIG_W]             = 8'(trig);
		w[`LED_LSB +: `LED_W]               = 7'(led);
		w[`ATTEN_BIT]                       = (atten != 0);
		w[`CHARGE_SEL_LSB +: `CHARGE_SEL_W] = 2'(sel);
		w[`ASYNC_BIT]                       = (async != 0);
		return w;
	endfunction

	function automatic void addStep(input logic [31:0] word, input int ack, input int fires,
		input int hold, input int trig, input int led, input int atten, input int adc,
		input logic [31:0] irq, input int emerg);
		stepT s;
		s.word  = word;
		s.ack   = (ack != 0);
		s.fires = (fires != 0);
		s.hold  = 8'(hold);
		s.trig  = 8'(trig);
		s.led   = 7'(led);
		s.atten = (atten != 0);
		s.adc   = (adc != 0);
		s.irq   = irq;
		s.emerg = (emerg != 0);
		steps.push_back(s);
	endfunction

	// expected pulse starts at N+3 plus the delay and lasts pulseLen cycles
	always @(negedge txCLK)
	begin
		logic [7:0] expPulse;
		int         rise;
		if (cycles > cycleLimit)
		begin
			$display("Timeout: the run went past its limit of %0d cycles", cycleLimit);
			$display("Something failed");
			$fatal(1, "run did not finish");
		end
		if (DUT.props.failures != 0)
		begin
			$display("A property assertion failed, see the error above");
			$display("Something failed");
			$fatal(1, "assertion failure");
		end
		if (!reset)
		begin
			for (int i = 0; i < `CHANNELS; i++)
			begin
				rise = fireEdge + 3 + int'(delays[i]);
				expPulse[i] = fireArmed && fireMask[i] && (cycles >= rise)
					&& (cycles < rise + pulseLen);
			end
			check(32'(transducerOutput), 32'(expPulse), "transducerOutput");
		end
	end

	initial
	begin
		int   now;
		int   longest;
		stepT s;
		reset             = 1'b1;
		controlComms      = '0;
		chargeTimeReg     = chargeReg;
		phaseDelay01      = {delays[1], delays[0]};
		phaseDelay23      = {delays[3], delays[2]};
		phaseDelay45      = {delays[5], delays[4]};
		phaseDelay67      = {delays[7], delays[6]};
		triggerRestLevels = 8'(trigRest);
		ledRestLevels     = 7'(ledRest);
		transducerMask    = maskValue;
		adcTriggerAck     = 1'b0;

		// word, ack, fires, hold, then trig, led, atten, adc, irq, emergency
		addStep(32'h0, 0, 0, 0, trigRest, ledRest, 0, 0, 32'h0, 0);
		addStep(pioWord(trigCmd, 'h0F, 'h11, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0, 32'h1, 0);
		addStep(pioWord(trigCmd, 'hF0, 'h7F, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0, 32'h1, 0);
		addStep(pioWord(clearCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0, 32'h0, 0);
		addStep(pioWord(issueCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 1, 32'h1, 0);
		addStep(pioWord(issueCmd, 0, 0, 0, 0, 0), 1, 0, 0, 'hAA, 'h3D, 0, 0, 32'h9, 0);
		addStep(pioWord(clearCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0, 32'h0, 0);
		addStep(pioWord(issueCmd, 0, 0, 0, 0, 1), 0, 0, 0, 'hAA, 'h3D, 0, 1, 32'h1, 0);
		addStep(pioWord(issueCmd, 0, 0, 0, 0, 1), 1, 0, 0, 'hAA, 'h3D, 0, 0, 32'h1, 0);
		addStep(pioWord(attenCmd, 0, 0, 1, 0, 0), 0, 0, 0, 'hAA, 'h3D, 1, 0, 32'h1, 0);
		addStep(pioWord(clearCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 1, 0, 32'h0, 0);
		addStep(pioWord(attenCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0, 32'h1, 0);
		addStep(pioWord(phaseCmd, 0, 0, 0, chargeSelUsed, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0,
			32'h1, 0);
		addStep(pioWord(fireCmd, 0, 0, 0, 0, 0), 0, 1, 0, 'hAA, 'h3D, 0, 0, 32'h1, 0);
		addStep(pioWord(fireCmd | phaseCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0,
			32'h8000_0001, 1);
		addStep(pioWord(fireCmd | phaseCmd, 0, 0, 0, 0, 0), 0, 0, 16, 'hAA, 'h3D, 0, 0,
			32'h8000_0001, 1);
		addStep(pioWord(clearCmd, 0, 0, 0, 0, 0), 0, 0, 0, 'hAA, 'h3D, 0, 0, 32'h0, 1);
		addStep(32'h0, 0, 0, 0, trigRest, ledRest, 0, 0, 32'h0, 1);   // back to idle

		longest = 0;
		foreach (delays[i])
			if (int'(delays[i]) > longest)
				longest = int'(delays[i]);
		cycleLimit = 4 + 3 + longest + pulseLen + 10;
		foreach (steps[k])
			cycleLimit += int'(steps[k].hold) + 6;

		repeat (4) @(posedge txCLK);
		reset <= 1'b0;

		foreach (steps[k])
		begin
			s = steps[k];
			@(negedge txCLK);
			now = cycles;
			@(posedge txCLK);
			controlComms  <= s.word;
			adcTriggerAck <= s.ack;
			if (s.fires)
			begin
				fireEdge  <= now + 2;   // edge that first samples this word
				fireArmed <= 1'b1;
				fireMask  <= transducerMask;
			end
			repeat (3 + int'(s.hold)) @(posedge txCLK);
			@(negedge txCLK);
			check(32'(triggerOutputs), 32'(s.trig), "triggerOutputs");
			check(32'(ledOutputs), 32'(s.led), "ledOutputs");
			check(32'(varRxAtten), 32'(s.atten), "varRxAtten");
			check(32'(adcTriggerLine), 32'(s.adc), "adcTriggerLine");
			check(interrupt, s.irq, "interrupt");
			check(32'(emergency), 32'(s.emerg), "emergency");
		end

		// an assertion on the last edges is counted before this negedge
		if (DUT.props.failures != 0)
		begin
			$display("A property assertion failed, see the error above");
			$display("Something failed");
			$fatal(1, "assertion failure");
		end
		else
		begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

//--- txController.f
+incdir+include
hw/txControllerPkg.sv
hw/pioCommandDecoder.sv
hw/pioSequencer.sv
hw/pulseChannel.sv
hw/txController.sv
verif/txController_properties.sv
verif/txControllerTb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f txController.f \
	--top-module txControllerTb -o txControllerSim; then
	echo "Verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/txControllerSim +verilator+error+limit+100)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -qx "Everything OK"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
